// ==== list.f ====
video_pkg.sv
vt_config_sync.sv
vt_frame_timer.sv
vt_line_buffer.sv
vt_pixel_pipe.sv
video_timing.sv
tb_checker.sv
tb_video_timing.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the video timing testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_video_timing \
   -f list.f -o sim_video_timing

out=$(./obj_dir/sim_video_timing)
echo "$out"

echo "$out" | grep -q "ALL TESTS PASSED"

// ==== tb_video_timing.sv ====
//////////////////////////////
// Video timing testbench
// One small mode per pixel depth loaded through the
// config handshake and run for two frames
//////////////////////////////

`default_nettype none

module tb_video_timing;

   // One mode with its palette seed and expected line and frame sizes
   typedef struct packed {
      video_pkg::timing_cfg_t cfg;
      logic [11:0]            pal_seed;
      logic [11:0]            exp_line;
      logic [11:0]            exp_lines;
   } test_row_t;

   localparam int NUM_ROWS    = 4;
   localparam int PIPE_DEPTH  = 4;
   localparam int ACK_LIMIT   = 50;
   localparam int FRAME_LIMIT = 4000;
   localparam int MARGIN      = 20000;

   logic                   pclk = 1'b0;
   logic                   reset;
   video_pkg::timing_cfg_t cfg;
   logic                   cfg_req;
   logic                   cfg_ack;
   video_pkg::lb_write_t   lb_wr;
   logic [video_pkg::PAL_ENTRIES-1:0][video_pkg::PAL_COL_W-1:0] palette;
   video_pkg::video_out_t  video;
   logic                   check_en;
   logic [11:0]            exp_line;
   logic [11:0]            exp_lines;

   test_row_t rows [NUM_ROWS];
   logic      table_ready = 1'b0;
   int        seed;
   int        tb_errors;
   logic [31:0] wr_words [512];

   always #50 pclk = ~pclk;

   video_timing video_timing_i (
      .i_pclk    (pclk),
      .i_reset   (reset),
      .i_cfg     (cfg),
      .i_cfg_req (cfg_req),
      .o_cfg_ack (cfg_ack),
      .i_lb_wr   (lb_wr),
      .i_palette (palette),
      .o_video   (video)
   );

   tb_checker checker_i (
      .i_pclk      (pclk),
      .i_reset     (reset),
      .i_check_en  (check_en),
      .i_cfg_req   (cfg_req),
      .i_cfg_ack   (cfg_ack),
      .i_cfg       (cfg),
      .i_exp_line  (exp_line),
      .i_exp_lines (exp_lines),
      .i_video     (video)
   );

   function automatic test_row_t make_row(
      input int h_res, input int h_fp, input int h_sync, input int h_bp,
      input int v_res, input int v_fp, input int v_sync, input int v_bp,
      input int wpl_m1, input logic [2:0] bpp, input logic [11:0] pal_seed,
      input int line_len, input int frame_lines);
      test_row_t r;
      r.cfg.h_res             = 11'(h_res);
      r.cfg.h_fp              = 11'(h_fp);
      r.cfg.h_sync            = 11'(h_sync);
      r.cfg.h_bp              = 11'(h_bp);
      r.cfg.v_res             = 11'(v_res);
      r.cfg.v_fp              = 11'(v_fp);
      r.cfg.v_sync            = 11'(v_sync);
      r.cfg.v_bp              = 11'(v_bp);
      r.cfg.words_per_line_m1 = 8'(wpl_m1);
      r.cfg.bpp               = bpp;
      r.pal_seed              = pal_seed;
      r.exp_line              = 12'(line_len);
      r.exp_lines             = 12'(frame_lines);
      return r;
   endfunction

   // Random palette and buffer words mirrored into the monitor
   task automatic make_row_data(input test_row_t row);
      int words;
      words = int'(row.cfg.words_per_line_m1) + 1;
      for (int i = 0; i < video_pkg::PAL_ENTRIES; i++) begin
         palette[i] = 12'($random(seed)) ^ row.pal_seed;
         checker_i.pal_copy[i] = palette[i];
      end
      for (int h = 0; h < 2; h++) begin
         for (int w = 0; w < words; w++) begin
            wr_words[h * 256 + w] = $random(seed);
            checker_i.lb_copy[h * 256 + w] = wr_words[h * 256 + w];
         end
      end
   endtask

   // Toggle the request and wait for the ack to match
   task automatic request_config(input test_row_t row);
      int cycles;
      cycles = 0;
      cfg = row.cfg;
      @(negedge pclk);
      cfg_req = ~cfg_req;
      while (cfg_ack !== cfg_req && cycles < ACK_LIMIT) begin
         @(negedge pclk);
         cycles++;
      end
      if (cfg_ack !== cfg_req) begin
         tb_errors++;
         $display("No configuration acknowledge within %0d cycles", ACK_LIMIT);
      end
   endtask

   // Half 0 then half 1 at one word per cycle
   task automatic write_line_buffer(input test_row_t row);
      int words;
      words = int'(row.cfg.words_per_line_m1) + 1;
      for (int h = 0; h < 2; h++) begin
         for (int w = 0; w < words; w++) begin
            lb_wr.valid = 1'b1;
            lb_wr.data  = wr_words[h * 256 + w];
            @(negedge pclk);
         end
      end
      lb_wr.valid = 1'b0;
   endtask

   task automatic wait_frames(input int n);
      int   seen;
      int   cycles;
      logic vs_prev;
      seen    = 0;
      cycles  = 0;
      vs_prev = video.vsync;
      while (seen < n && cycles < FRAME_LIMIT) begin
         @(negedge pclk);
         cycles++;
         if (video.vsync === 1'b1 && vs_prev === 1'b0) begin
            seen++;
         end
         vs_prev = video.vsync;
      end
      if (seen < n) begin
         tb_errors++;
         $display("Only %0d of %0d frames arrived within %0d cycles", seen, n, FRAME_LIMIT);
      end
      // Monitor sees the last vsync edge one clock later
      @(negedge pclk);
   endtask

   //////////////////////////////
   // Main sequence

   initial begin
      int total;
      reset     = 1'b1;
      cfg       = '0;
      cfg_req   = 1'b0;
      lb_wr     = '0;
      palette   = '0;
      check_en  = 1'b0;
      exp_line  = '0;
      exp_lines = '0;
      seed      = 32'h8de4519c;
      tb_errors = 0;

      // h_res fp sync bp, v_res fp sync bp, wpl-1, depth, seed, line, frame
      rows[0] = make_row(64, 2, 4, 3, 4, 1, 2, 2, 1, video_pkg::BPP_1, 12'h5a3, 73, 9);
      rows[1] = make_row(32, 3, 3, 4, 5, 2, 1, 1, 1, video_pkg::BPP_2, 12'h0f0, 42, 9);
      rows[2] = make_row(24, 1, 2, 2, 4, 1, 2, 1, 2, video_pkg::BPP_4, 12'h3c7, 29, 8);
      rows[3] = make_row(20, 2, 3, 3, 3, 1, 1, 2, 4, video_pkg::BPP_8, 12'hf18, 28, 7);
      table_ready = 1'b1;

      repeat (2) @(negedge pclk);
      reset = 1'b0;

      for (int i = 0; i < NUM_ROWS; i++) begin
         check_en  = 1'b0;
         make_row_data(rows[i]);
         exp_line  = rows[i].exp_line;
         exp_lines = rows[i].exp_lines;
         request_config(rows[i]);
         // Restart cleared the write pointer
         write_line_buffer(rows[i]);
         repeat (PIPE_DEPTH) @(negedge pclk);
         check_en = 1'b1;
         wait_frames(2);
      end
      check_en = 1'b0;

      checker_i.check_ack_count();

      total = tb_errors + checker_i.timing_errors + checker_i.pixel_errors
              + checker_i.handshake_errors;
      $display("Errors: timing %0d, pixel %0d, handshake %0d, sequence %0d",
               checker_i.timing_errors, checker_i.pixel_errors,
               checker_i.handshake_errors, tb_errors);
      if (total == 0) begin
         $display("ALL TESTS PASSED");
      end else begin
         $display("SOME TESTS FAILED");
      end
      $finish;
   end

   // Watchdog allows three frames per mode plus setup
   initial begin
      longint limit;
      wait (table_ready);
      limit = MARGIN;
      for (int i = 0; i < NUM_ROWS; i++) begin
         limit += 3 * longint'(rows[i].exp_line) * longint'(rows[i].exp_lines) * 100;
      end
      #(limit);
      $display("Timeout: the run did not finish within %0d time units", limit);
      $display("SOME TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb_checker.sv ====
//////////////////////////////
// Video timing monitor
// Measures sync, enable and frame timing on the output stream
// and compares every displayed pixel with a reference model
//////////////////////////////

`default_nettype none

module tb_checker (
   input wire logic                   i_pclk,
   input wire logic                   i_reset,
   input wire logic                   i_check_en,
   input wire logic                   i_cfg_req,
   input wire logic                   i_cfg_ack,
   input wire video_pkg::timing_cfg_t i_cfg,
   input wire logic [11:0]            i_exp_line,
   input wire logic [11:0]            i_exp_lines,
   input wire video_pkg::video_out_t  i_video
);

   // Reference copies loaded by the testbench before each run
   logic [31:0] lb_copy [512];
   logic [11:0] pal_copy [16];

   int timing_errors = 0;
   int pixel_errors = 0;
   int handshake_errors = 0;
   int req_toggles = 0;
   int ack_toggles = 0;

   // Previous output levels
   logic hs_q;
   logic vs_q;
   logic de_q;
   logic en_q = 1'b0;
   logic ack_q;
   logic req_q;
   // A rising edge was seen since checking began
   logic hs_armed;
   logic vs_armed;
   // Cycles since hsync rose and lines since vsync rose
   int   hs_age;
   int   hline;
   int   vs_w;
   // Position within the displayed frame
   int   run_len;
   int   runs;
   int   y;
   logic [23:0] exp_rgb;

   // Channel nibble repeated down into the low bits
   function automatic logic [7:0] stretch4(input logic [3:0] nib);
      stretch4 = {nib, nib[3], nib[3], nib[3], nib[3]};
   endfunction

   // Colour of display pixel k on display line ln
   function automatic logic [23:0] expected_rgb(input int ln, input int k);
      int          bits;
      int          ppw;
      logic [31:0] word;
      logic [7:0]  pix;
      logic [11:0] ent;
      logic [3:0]  r;
      logic [3:0]  g;
      logic [3:0]  b;
      bits = 1 << i_cfg.bpp;
      ppw  = 32 / bits;
      word = lb_copy[(ln % 2) * 256 + k / ppw];
      // Leftmost pixel in the lowest bits
      pix  = 8'((word >> ((k % ppw) * bits)) & ((1 << bits) - 1));
      ent  = pal_copy[pix[3:0]];
      b    = ent[11:8];
      g    = ent[7:4];
      r    = ent[3:0];
      // At 8 bpp the top bits of each gun come straight from the pixel
      if (i_cfg.bpp == video_pkg::BPP_8) begin
         b[3]   = pix[7];
         g[3:2] = pix[6:5];
         r[3]   = pix[4];
      end
      expected_rgb = {stretch4(r), stretch4(g), stretch4(b)};
   endfunction

   task automatic check_channel(input string name, input logic [7:0] exp_val,
                                input logic [7:0] got);
      if (got !== exp_val) begin
         pixel_errors++;
         $display("Error %s at line %0d pixel %0d: expected %h, got %h",
                  name, y, run_len, exp_val, got);
      end
   endtask

   task automatic timing_mismatch(input string name, input int exp_val, input int got);
      timing_errors++;
      $display("Error %s: expected %h, got %h", name, exp_val, got);
   endtask

   // Each request must have been answered by exactly one ack toggle
   task automatic check_ack_count();
      if (ack_toggles != req_toggles) begin
         handshake_errors++;
         $display("Error o_cfg_ack toggles: expected %h, got %h",
                  req_toggles, ack_toggles);
      end
   endtask

   //////////////////////////////
   // Handshake

   // Every ack toggle needs its own request and ack is 0 out of reset
   always @(posedge i_pclk) begin
      if (i_reset) begin
         ack_q = 1'b0;
         req_q = i_cfg_req;
      end else begin
         if (i_cfg_req !== req_q) begin
            req_toggles++;
         end
         req_q = i_cfg_req;
         if (i_cfg_ack !== ack_q) begin
            ack_toggles++;
            if (ack_toggles > req_toggles) begin
               handshake_errors++;
               $display("Acknowledge toggled with no open request at time %0t", $time);
            end
         end
         ack_q = i_cfg_ack;
      end
   end

   //////////////////////////////
   // Timing and pixels

   always @(posedge i_pclk) begin
      if (i_check_en && !en_q) begin
         hs_armed = 1'b0;
         vs_armed = 1'b0;
         hs_age   = 0;
         hline    = 0;
         vs_w     = 0;
         run_len  = 0;
         runs     = 0;
         y        = 0;
      end

      if (i_check_en) begin
         if (i_video.blank !== ~i_video.de) begin
            timing_mismatch("o_video.blank", int'(~i_video.de), int'(i_video.blank));
         end

         // Frame boundary is checked before the line that starts with it
         if (i_video.vsync && !vs_q) begin
            if (vs_armed && hline != int'(i_exp_lines)) begin
               timing_mismatch("o_video.vsync lines per frame", int'(i_exp_lines), hline);
            end
            if (runs != int'(i_cfg.v_res)) begin
               timing_mismatch("o_video.de runs per frame", int'(i_cfg.v_res), runs);
            end
            vs_armed = 1'b1;
            hline    = 0;
            vs_w     = 0;
            runs     = 0;
            y        = 0;
         end
         if (!i_video.vsync && vs_q && vs_armed && vs_w != int'(i_cfg.v_sync)) begin
            timing_mismatch("o_video.vsync width", int'(i_cfg.v_sync), vs_w);
         end

         // Line boundary
         if (i_video.hsync && !hs_q) begin
            if (hs_armed && hs_age != int'(i_exp_line)) begin
               timing_mismatch("o_video.hsync line length", int'(i_exp_line), hs_age);
            end
            hs_armed = 1'b1;
            hs_age   = 1;
            hline++;
            if (i_video.vsync) begin
               vs_w++;
            end
         end else begin
            if (!i_video.hsync && hs_q && hs_armed && hs_age != int'(i_cfg.h_sync)) begin
               timing_mismatch("o_video.hsync width", int'(i_cfg.h_sync), hs_age);
            end
            hs_age++;
         end

         // Displayed pixels
         if (i_video.de) begin
            exp_rgb = expected_rgb(y, run_len);
            check_channel("o_video.r", exp_rgb[23:16], i_video.r);
            check_channel("o_video.g", exp_rgb[15:8], i_video.g);
            check_channel("o_video.b", exp_rgb[7:0], i_video.b);
            run_len++;
         end else if (de_q) begin
            if (run_len != int'(i_cfg.h_res)) begin
               timing_mismatch("o_video.de run length", int'(i_cfg.h_res), run_len);
            end
            runs++;
            y++;
            run_len = 0;
         end
      end

      hs_q = i_video.hsync;
      vs_q = i_video.vsync;
      de_q = i_video.de;
      en_q = i_check_en;
   end

endmodule

`default_nettype wire

// ==== video_timing.sv ====
//////////////////////////////
// Video timing engine
// Timing generation and line buffer scan-out to 8-bit RGB
//////////////////////////////

`default_nettype none

module video_timing (
   input  wire logic                   i_pclk,
   input  wire logic                   i_reset,
   input  wire video_pkg::timing_cfg_t i_cfg,
   input  wire logic                   i_cfg_req,
   output logic                        o_cfg_ack,
   input  wire video_pkg::lb_write_t   i_lb_wr,
   input  wire logic [video_pkg::PAL_ENTRIES-1:0][video_pkg::PAL_COL_W-1:0] i_palette,
   output video_pkg::video_out_t       o_video
);

   // Scan hold and captured limits, shared by all blocks
   logic                         restart;
   video_pkg::timing_lim_t       lim;
   // Stage 0 beat
   video_pkg::scan_t             scan;
   // Stage 1 line buffer data
   logic [video_pkg::WORD_W-1:0] rdata;

   vt_config_sync config_sync_i (
      .i_pclk    (i_pclk),
      .i_reset   (i_reset),
      .i_cfg     (i_cfg),
      .i_cfg_req (i_cfg_req),
      .o_cfg_ack (o_cfg_ack),
      .o_restart (restart),
      .o_lim     (lim)
   );

   vt_frame_timer frame_timer_i (
      .i_pclk    (i_pclk),
      .i_restart (restart),
      .i_lim     (lim),
      .o_scan    (scan)
   );

   // Read address follows the display coordinates
   vt_line_buffer line_buffer_i (
      .i_pclk    (i_pclk),
      .i_restart (restart),
      .i_lim     (lim),
      .i_lb_wr   (i_lb_wr),
      .i_dispx   (scan.dispx),
      .i_dispy   (scan.dispy),
      .o_rdata   (rdata)
   );

   vt_pixel_pipe pixel_pipe_i (
      .i_pclk    (i_pclk),
      .i_lim     (lim),
      .i_scan    (scan),
      .i_rdata   (rdata),
      .i_palette (i_palette),
      .o_video   (o_video)
   );

endmodule

`default_nettype wire

// ==== vt_pixel_pipe.sv ====
//////////////////////////////
// Pixel output pipeline
// Demux, palette lookup and widening, with the syncs delayed
// to match, four cycles from stage 0 to the output
//////////////////////////////

`default_nettype none

module vt_pixel_pipe (
   input  wire logic                        i_pclk,
   input  wire video_pkg::timing_lim_t      i_lim,
   input  wire video_pkg::scan_t            i_scan,
   input  wire logic [video_pkg::WORD_W-1:0] i_rdata,
   input  wire logic [video_pkg::PAL_ENTRIES-1:0][video_pkg::PAL_COL_W-1:0] i_palette,
   output video_pkg::video_out_t            o_video
);

   // Stage 1, alongside the RAM read data
   logic                        hsync1;
   logic                        vsync1;
   logic                        de1;
   logic [4:0]                  xidx1;
   // Stage 2, picked pixel
   logic                        hsync2;
   logic                        vsync2;
   logic                        de2;
   logic [7:0]                  pix_sel;
   logic [7:0]                  pix2;
   // Stage 3, widened colour
   logic                        hsync3;
   logic                        vsync3;
   logic                        de3;
   logic [video_pkg::PAL_COL_W-1:0] pal_entry;
   logic [video_pkg::PAL_COL_W-1:0] colour;
   logic [video_pkg::CH_W-1:0]  r3;
   logic [video_pkg::CH_W-1:0]  g3;
   logic [video_pkg::CH_W-1:0]  b3;

   // 4-bit channel to output width, low bits repeat bit 3
   function automatic logic [video_pkg::CH_W-1:0] widen(input logic [3:0] ch);
      widen = {ch, {(video_pkg::CH_W-4){ch[3]}}};
   endfunction

   //////////////////////////////
   // Stage 0 to 1

   // Pixel-in-word index travels with the read
   always_ff @(posedge i_pclk) begin
      hsync1 <= i_scan.hsync;
      vsync1 <= i_scan.vsync;
      de1    <= i_scan.de;
      xidx1  <= i_scan.dispx[4:0];
   end

   //////////////////////////////
   // Stage 1 to 2

   // Lowest bits hold the leftmost pixel, narrow pixels zero-extended
   always_comb begin
      pix_sel = '0;
      case (i_lim.bpp)
         video_pkg::BPP_1: pix_sel[0]   = i_rdata[xidx1];
         video_pkg::BPP_2: pix_sel[1:0] = i_rdata[{xidx1[3:0], 1'b0} +: 2];
         video_pkg::BPP_4: pix_sel[3:0] = i_rdata[{xidx1[2:0], 2'b00} +: 4];
         default:          pix_sel      = i_rdata[{xidx1[1:0], 3'b000} +: 8];
      endcase
   end

   always_ff @(posedge i_pclk) begin
      hsync2 <= hsync1;
      vsync2 <= vsync1;
      de2    <= de1;
      pix2   <= pix_sel;
   end

   //////////////////////////////
   // Stage 2 to 3

   // Low nibble indexes the palette at every depth
   assign pal_entry = i_palette[pix2[3:0]];

   // 8 bpp takes the top bits of each channel from the pixel itself
   always_comb begin
      if (i_lim.bpp == video_pkg::BPP_8) begin
         colour = {pix2[7], pal_entry[10:8],
                   pix2[6:5], pal_entry[5:4],
                   pix2[4], pal_entry[2:0]};
      end else begin
         colour = pal_entry;
      end
   end

   // Palette layout is blue high, red low
   always_ff @(posedge i_pclk) begin
      hsync3 <= hsync2;
      vsync3 <= vsync2;
      de3    <= de2;
      r3     <= widen(colour[3:0]);
      g3     <= widen(colour[7:4]);
      b3     <= widen(colour[11:8]);
   end

   //////////////////////////////
   // Stage 3 to 4

   always_ff @(posedge i_pclk) begin
      o_video.r     <= r3;
      o_video.g     <= g3;
      o_video.b     <= b3;
      o_video.hsync <= hsync3;
      o_video.vsync <= vsync3;
      o_video.blank <= ~de3;
      o_video.de    <= de3;
   end

endmodule

`default_nettype wire

// ==== vt_line_buffer.sv ====
//////////////////////////////
// Double line buffer
// Even display lines read half 0, odd lines half 1
//////////////////////////////

`default_nettype none

module vt_line_buffer (
   input  wire logic                        i_pclk,
   input  wire logic                        i_restart,
   input  wire video_pkg::timing_lim_t      i_lim,
   input  wire video_pkg::lb_write_t        i_lb_wr,
   input  wire logic [video_pkg::CTR_W-1:0] i_dispx,
   input  wire logic [video_pkg::CTR_W-1:0] i_dispy,
   output logic [video_pkg::WORD_W-1:0]     o_rdata
);

   // Two halves of 256 words
   logic [video_pkg::WORD_W-1:0]    mem [2**video_pkg::LB_ADDR_W];
   logic [video_pkg::LB_ADDR_W-1:0] wr_ptr;
   logic [video_pkg::LB_ADDR_W-1:0] rd_addr;

   //////////////////////////////
   // Write side

   // Top bit is the half, the rest the word within the line
   always_ff @(posedge i_pclk) begin
      if (i_restart) begin
         wr_ptr <= '0;
      end else if (i_lb_wr.valid) begin
         if (wr_ptr[video_pkg::WPL_W-1:0] == i_lim.words_per_line_m1) begin
            // Line full, start the other half
            wr_ptr <= {~wr_ptr[video_pkg::LB_ADDR_W-1], {video_pkg::WPL_W{1'b0}}};
         end else begin
            wr_ptr <= wr_ptr + 1'b1;
         end
      end
   end

   always_ff @(posedge i_pclk) begin
      if (i_lb_wr.valid) begin
         mem[wr_ptr] <= i_lb_wr.data;
      end
   end

   //////////////////////////////
   // Read side

   // Word index is dispx divided by pixels per word
   always_comb begin
      case (i_lim.bpp)
         video_pkg::BPP_1: rd_addr = {i_dispy[0], 2'b00, i_dispx[10:5]};
         video_pkg::BPP_2: rd_addr = {i_dispy[0], 1'b0, i_dispx[10:4]};
         video_pkg::BPP_4: rd_addr = {i_dispy[0], i_dispx[10:3]};
         default:          rd_addr = {i_dispy[0], i_dispx[9:2]};
      endcase
   end

   // Registered read, data is on stage 1
   always_ff @(posedge i_pclk) begin
      o_rdata <= mem[rd_addr];
   end

endmodule

`default_nettype wire

// ==== vt_frame_timer.sv ====
//////////////////////////////
// Frame timer
// Pixel and line counters, sync and enable edges, and the
// logical display coordinates
//////////////////////////////

`default_nettype none

module vt_frame_timer (
   input  wire logic                   i_pclk,
   input  wire logic                   i_restart,
   input  wire video_pkg::timing_lim_t i_lim,
   output video_pkg::scan_t            o_scan
);

   // Physical scan position
   logic [video_pkg::CTR_W-1:0] px;
   logic [video_pkg::CTR_W-1:0] py;
   // Current line lies inside the vertical display window
   logic                        v_on_display;

   //////////////////////////////
   // Horizontal and vertical scan

   always_ff @(posedge i_pclk) begin
      if (i_restart) begin
         // Park on the line just before the first display line
         px              <= '0;
         py              <= i_lim.v_disp_start;
         v_on_display    <= 1'b0;
         o_scan.hsync    <= 1'b1;
         o_scan.vsync    <= 1'b0;
         o_scan.de       <= 1'b0;
         o_scan.dispx    <= '0;
         o_scan.dispy    <= '0;
      end else if (px == i_lim.h_total) begin
         // End of line
         px           <= '0;
         o_scan.hsync <= 1'b1;
         o_scan.de    <= 1'b0;
         o_scan.dispx <= '0;

         if (py == i_lim.v_total) begin
            py           <= '0;
            o_scan.vsync <= 1'b1;
         end else begin
            py <= py + 1'b1;
            if (py == i_lim.v_sync_off) begin
               o_scan.vsync <= 1'b0;
            end
         end

         // Vertical window, entered after v_disp_start, left after v_disp_end
         if (py == i_lim.v_disp_start) begin
            v_on_display <= 1'b1;
            o_scan.dispy <= '0;
         end else if (py == i_lim.v_disp_end) begin
            v_on_display <= 1'b0;
            o_scan.dispy <= '0;
         end else if (v_on_display) begin
            o_scan.dispy <= o_scan.dispy + 1'b1;
         end
      end else begin
         px <= px + 1'b1;

         // Display pixel index, restarts each line
         if (o_scan.de) begin
            o_scan.dispx <= o_scan.dispx + 1'b1;
         end else begin
            o_scan.dispx <= '0;
         end

         // Sync falls at the end of the sync width
         if (px == i_lim.h_sync_off) begin
            o_scan.hsync <= 1'b0;
         end

         // Enable covers h_res pixels
         if (px == i_lim.h_disp_start && v_on_display) begin
            o_scan.de <= 1'b1;
         end
         if (px == i_lim.h_disp_end) begin
            o_scan.de <= 1'b0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== vt_config_sync.sv ====
//////////////////////////////
// Configuration handshake
// Syncs the toggle request, holds the scan for a few cycles
// and captures the derived timing limits
//////////////////////////////

`default_nettype none

module vt_config_sync (
   input  wire logic                   i_pclk,
   input  wire logic                   i_reset,
   input  wire video_pkg::timing_cfg_t i_cfg,
   input  wire logic                   i_cfg_req,
   output logic                        o_cfg_ack,
   output logic                        o_restart,
   output video_pkg::timing_lim_t      o_lim
);

   // Two-flop synchroniser on the toggle request
   logic [1:0] req_sync;
   // Counts the hold, restart is high while it runs
   logic [$clog2(video_pkg::HOLD_CYCLES+1)-1:0] hold_ctr;
   // Hold came from a request, so ack at its end
   logic       ack_due;
   logic       req_pending;

   always_ff @(posedge i_pclk) begin
      if (i_reset) begin
         req_sync <= '0;
      end else begin
         req_sync <= {req_sync[0], i_cfg_req};
      end
   end

   // A request is open while the synced level differs from the ack
   assign req_pending = req_sync[1] != o_cfg_ack;

   //////////////////////////////
   // Hold sequencer

   always_ff @(posedge i_pclk) begin
      if (i_reset) begin
         // Reset runs the same hold, but owes no ack
         o_restart <= 1'b1;
         hold_ctr  <= '0;
         ack_due   <= 1'b0;
         o_cfg_ack <= 1'b0;
      end else if (!o_restart) begin
         if (req_pending) begin
            o_restart <= 1'b1;
            hold_ctr  <= '0;
            ack_due   <= 1'b1;
         end
      end else if (hold_ctr != video_pkg::HOLD_CYCLES) begin
         hold_ctr <= hold_ctr + 1'b1;
      end else begin
         // Release the scan, ack in the same cycle
         o_restart <= 1'b0;
         ack_due   <= 1'b0;
         if (ack_due) begin
            o_cfg_ack <= ~o_cfg_ack;
         end
      end
   end

   //////////////////////////////
   // Limit capture

   // Syncs sit at coordinate 0, display starts after the back porch
   always_ff @(posedge i_pclk) begin
      if (o_restart) begin
         o_lim.h_sync_off   <= i_cfg.h_sync - 1'b1;
         o_lim.h_disp_start <= i_cfg.h_sync + i_cfg.h_bp - 1'b1;
         o_lim.h_disp_end   <= i_cfg.h_sync + i_cfg.h_bp + i_cfg.h_res - 1'b1;
         o_lim.h_total      <= i_cfg.h_sync + i_cfg.h_bp + i_cfg.h_res + i_cfg.h_fp - 1'b1;
         o_lim.v_sync_off   <= i_cfg.v_sync - 1'b1;
         o_lim.v_disp_start <= i_cfg.v_sync + i_cfg.v_bp - 1'b1;
         o_lim.v_disp_end   <= i_cfg.v_sync + i_cfg.v_bp + i_cfg.v_res - 1'b1;
         o_lim.v_total      <= i_cfg.v_sync + i_cfg.v_bp + i_cfg.v_res + i_cfg.v_fp - 1'b1;
         o_lim.bpp          <= i_cfg.bpp;
         // Line buffer wrap point
         o_lim.words_per_line_m1 <= i_cfg.words_per_line_m1;
      end
   end

endmodule

`default_nettype wire

// ==== video_pkg.sv ====
//////////////////////////////
// Video timing package
// Widths, pixel-depth codes and the packed records shared by
// the timing engine blocks
//////////////////////////////

`default_nettype none

package video_pkg;

   // Timing counters and configuration fields
   localparam int CTR_W       = 11;
   // Line buffer word
   localparam int WORD_W      = 32;
   // One bit for the half, eight for the word
   localparam int LB_ADDR_W   = 9;
   localparam int WPL_W       = 8;
   // VIDC palette, 4 bits each of blue, green, red
   localparam int PAL_ENTRIES = 16;
   localparam int PAL_COL_W   = 12;
   // Output channel width
   localparam int CH_W        = 8;
   // Scan held this many cycles beyond the first on restart
   localparam int HOLD_CYCLES = 3;

   // Pixel depth codes
   localparam logic [2:0] BPP_1 = 3'd0;
   localparam logic [2:0] BPP_2 = 3'd1;
   localparam logic [2:0] BPP_4 = 3'd2;
   localparam logic [2:0] BPP_8 = 3'd3;

   // Raw configuration as the host supplies it
   typedef struct packed {
      logic [CTR_W-1:0] h_res;
      logic [CTR_W-1:0] h_fp;
      logic [CTR_W-1:0] h_sync;
      logic [CTR_W-1:0] h_bp;
      logic [CTR_W-1:0] v_res;
      logic [CTR_W-1:0] v_fp;
      logic [CTR_W-1:0] v_sync;
      logic [CTR_W-1:0] v_bp;
      logic [WPL_W-1:0] words_per_line_m1;
      logic [2:0]       bpp;
   } timing_cfg_t;

   // Cumulative limits, each the last px/py of its region
   typedef struct packed {
      logic [CTR_W-1:0] h_sync_off;
      logic [CTR_W-1:0] h_disp_start;
      logic [CTR_W-1:0] h_disp_end;
      logic [CTR_W-1:0] h_total;
      logic [CTR_W-1:0] v_sync_off;
      logic [CTR_W-1:0] v_disp_start;
      logic [CTR_W-1:0] v_disp_end;
      logic [CTR_W-1:0] v_total;
      logic [2:0]       bpp;
      logic [WPL_W-1:0] words_per_line_m1;
   } timing_lim_t;

   // Stage 0 beat from the frame timer
   typedef struct packed {
      logic             hsync;
      logic             vsync;
      logic             de;
      logic [CTR_W-1:0] dispx;
      logic [CTR_W-1:0] dispy;
   } scan_t;

   // Output beat
   typedef struct packed {
      logic [CH_W-1:0] r;
      logic [CH_W-1:0] g;
      logic [CH_W-1:0] b;
      logic            hsync;
      logic            vsync;
      logic            blank;
      logic            de;
   } video_out_t;

   // One line buffer write
   typedef struct packed {
      logic              valid;
      logic [WORD_W-1:0] data;
   } lb_write_t;

endpackage

`default_nettype wire
